//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_vdp
FILELIST  := vdp.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_vdp.sv
`timescale 1ns/1ps

module tb_vdp;
    import vdp_pkg::*;

    localparam int frame_cycles  = vdp_h_total * vdp_v_total;
    localparam int frame_checks  = 7;  // Frames compared over all tests
    localparam int timeout_cycles = (2 * frame_checks + 2) * frame_cycles + 2000;

    logic        clk;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic [31:0] dat_r;
    logic        ack;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic [2:0]  rgb;

    // Shadow of every register written by the testbench
    bit          sh_en [vdp_sprite_count];
    int          sh_x [vdp_sprite_count];
    int          sh_y [vdp_sprite_count];
    logic [31:0] sh_rows [vdp_sprite_count][vdp_sprite_height];
    logic [2:0]  sh_bg;

    logic [31:0] rand_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          test_errors_start;
    string       test_name;
    int          frames_requested;
    int          frames_done;

    vdp_top i_dut
    (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack),
        .hsync (hsync),
        .vsync (vsync),
        .de    (de),
        .rgb   (rgb)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Lowest opaque sprite wins, otherwise background
    function automatic logic [2:0] expected_rgb(input int x, input int y);
        logic [3:0] nib;
        for (int i = 0; i < vdp_sprite_count; i++)
        begin
            if (sh_en[i] && x >= sh_x[i] && x < sh_x[i] + vdp_sprite_width
                && y >= sh_y[i] && y < sh_y[i] + vdp_sprite_height)
            begin
                nib = 4'(sh_rows[i][y - sh_y[i]] >> (4 * (x - sh_x[i])));
                if (nib[3])
                    return nib[2:0];
            end
        end
        return sh_bg;
    endfunction

    // Vsync rises at column 0, so the column is the pixel count since then
    function automatic bit hsync_expected(input int phase);
        int x;
        x = phase % vdp_h_total;
        return x >= vdp_h_sync_start && x < vdp_h_sync_start + vdp_h_sync_len;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wb_cycle(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= addr;
        dat_w <= wdata;
        sel   <= 4'hf;
        do
        begin
            @(posedge clk);
            waited++;
        end while (!ack && waited < 16);
        rdata = dat_r;
        if (!ack)
        begin
            $display("bus error: no ack for address %h after %0d cycles", addr, waited);
            error_count++;
        end
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(posedge clk);
        check_value("ack", 32'd0, 32'(ack));  // Ack lasts one cycle only
    endtask

    task automatic wb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] ignored;
        wb_cycle(1'b1, addr, wdata, ignored);
    endtask

    task automatic wb_read(input logic [7:0] addr, output logic [31:0] rdata);
        wb_cycle(1'b0, addr, 32'd0, rdata);
    endtask

    task automatic set_background(input logic [2:0] colour);
        wb_write(8'h80, {29'd0, colour});
        sh_bg = colour;
    endtask

    task automatic set_sprite_pos(input int i, input bit en, input int x, input int y);
        wb_write(8'(i * 32), {en, 9'd0, 6'(y), 9'd0, 7'(x)});
        sh_en[i] = en;
        sh_x[i]  = x;
        sh_y[i]  = y;
    endtask

    task automatic set_sprite_row(input int i, input int r, input logic [31:0] word);
        wb_write(8'(i * 32 + 16 + r), word);
        sh_rows[i][r] = word;
    endtask

    // Odd cells opaque, even cells transparent with non-zero colour bits
    function automatic logic [31:0] pattern_row(input int r);
        logic [31:0] word;
        word = '0;
        for (int c = 0; c < vdp_sprite_width; c++)
            word[c * 4 +: 4] = ((r + c) % 2 == 1) ? {1'b1, 3'(r + c)} : 4'(c);
        return word;
    endfunction

    task automatic check_frame();
        @(posedge clk);
        frames_requested <= frames_requested + 1;
        @(posedge clk);
        while (frames_done != frames_requested)
            @(posedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_errors_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count != test_errors_start)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, test_name,
                 (error_count == test_errors_start) ? "ok" : "failed");
    endtask

    task automatic randomize_scene();
        set_background(3'(next_random() >> 16));
        for (int i = 0; i < vdp_sprite_count; i++)
        begin
            set_sprite_pos(i, 1'(next_random() >> 20), int'(next_random() >> 16) % 72,
                           int'(next_random() >> 16) % 52);
            for (int r = 0; r < vdp_sprite_height; r++)
                set_sprite_row(i, r, next_random());
        end
    endtask

    // Follows the output raster, frame start is the rising edge of vsync
    initial
    begin : compare_raster
        int col;
        int row;
        int pixels;
        int phase;
        bit checking;
        bit vsync_q;
        col      = 0;
        row      = 0;
        pixels   = 0;
        phase    = 0;
        checking = 1'b0;
        vsync_q  = 1'b0;
        forever
        begin
            @(posedge clk);
            phase++;
            if (vsync && !vsync_q)
            begin
                if (checking)
                begin
                    if (pixels != vdp_h_active * vdp_v_active)
                    begin
                        $display("raster error: %0d visible pixels in a frame", pixels);
                        error_count++;
                    end
                    checking = 1'b0;
                    frames_done <= frames_done + 1;
                end
                else if (frames_done != frames_requested)
                begin
                    checking = 1'b1;
                    pixels   = 0;
                end
                col   = 0;
                row   = 0;
                phase = 0;
            end
            else if (de)
            begin
                if (checking)
                begin
                    check_value("rgb", 32'(expected_rgb(col, row)), 32'(rgb));
                    pixels++;
                end
                col++;
                if (col == vdp_h_active)
                begin
                    col = 0;
                    row++;
                end
            end
            else if (checking)
                check_value("rgb", 32'd0, 32'(rgb));  // Blanking is black
            if (checking)
                check_value("hsync", 32'(hsync_expected(phase)), 32'(hsync));
            vsync_q = vsync;
        end
    end

    initial
    begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin : run_tests
        logic [31:0] rdata;
        reset            = 1'b1;
        cyc              = 1'b0;
        stb              = 1'b0;
        we               = 1'b0;
        adr              = '0;
        dat_w            = '0;
        sel              = '0;
        rand_state       = 32'hb06a_7dff;
        error_count      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        frames_requested = 0;
        frames_done      = 0;
        sh_bg            = '0;
        for (int i = 0; i < vdp_sprite_count; i++)
            sh_en[i] = 1'b0;

        begin_test("reset_defaults");
        repeat (8)
        begin
            @(posedge clk);
            check_value("de", 32'd0, 32'(de));
            check_value("hsync", 32'd0, 32'(hsync));
            check_value("vsync", 32'd0, 32'(vsync));
            check_value("ack", 32'd0, 32'(ack));
            check_value("rgb", 32'd0, 32'(rgb));
        end
        reset <= 1'b0;
        check_frame();
        end_test();

        begin_test("background_register");
        set_background(3'd5);
        wb_read(8'h80, rdata);
        check_value("dat_r", 32'd5, rdata);
        wb_read(8'h00, rdata);
        check_value("dat_r", 32'd0, rdata);
        wb_read(8'h35, rdata);
        check_value("dat_r", 32'd0, rdata);
        end_test();

        begin_test("single_sprite");
        set_background(3'd2);
        for (int r = 0; r < vdp_sprite_height; r++)
            set_sprite_row(0, r, pattern_row(r));
        set_sprite_pos(0, 1'b1, 20, 10);
        check_frame();
        end_test();

        begin_test("overlap_priority");
        for (int r = 0; r < vdp_sprite_height; r++)
        begin
            set_sprite_row(1, r, 32'heeee_eeee);
            set_sprite_row(2, r, 32'hffff_ffff);
        end
        set_sprite_pos(1, 1'b1, 24, 14);  // Shows through sprite 0 gaps
        set_sprite_pos(2, 1'b0, 22, 12);
        check_frame();
        end_test();

        begin_test("edge_clipping");
        for (int r = 0; r < vdp_sprite_height; r++)
            set_sprite_row(3, r, 32'h9999_9999);
        set_sprite_pos(3, 1'b1, 60, 44);
        set_sprite_pos(2, 1'b1, 62, 20);
        set_sprite_pos(1, 1'b1, 30, 45);
        check_frame();
        end_test();

        begin_test("random_frames");
        for (int f = 0; f < 3; f++)
        begin
            randomize_scene();
            check_frame();
        end
        end_test();

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- vdp.f
vdp_pkg.sv
vdp_timing.sv
vdp_wb_regs.sv
vdp_sprite.sv
vdp_mixer.sv
vdp_top.sv
tb_vdp.sv

//--- vdp_mixer.sv
`timescale 1ns/1ps

module vdp_mixer
(
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic [vdp_pkg::vdp_sprite_count - 1:0]                sprite_en,
    input  logic [vdp_pkg::vdp_sprite_count
                  * vdp_pkg::vdp_rgb_width - 1:0]                 sprite_rgb,
    input  logic [vdp_pkg::vdp_rgb_width - 1:0]                   bg_rgb,
    input  logic                                                  hsync_in,
    input  logic                                                  vsync_in,
    input  logic                                                  de_in,
    output logic                                                  hsync,
    output logic                                                  vsync,
    output logic                                                  de,
    output logic [vdp_pkg::vdp_rgb_width - 1:0]                   rgb
);
    import vdp_pkg::*;

    logic [vdp_rgb_width - 1:0] pick;
    logic                       hsync_d;
    logic                       vsync_d;
    logic                       de_d;

    // Walk from the highest index down so the lowest opaque sprite wins
    always_comb
    begin
        pick = bg_rgb;
        for (int i = vdp_sprite_count - 1; i >= 0; i--)
            if (sprite_en[i])
                pick = sprite_rgb[i * vdp_rgb_width +: vdp_rgb_width];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
            de_d    <= 1'b0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            de      <= 1'b0;
            rgb     <= '0;
        end
        else
        begin
            hsync_d <= hsync_in;  // Matches the sprite stage
            vsync_d <= vsync_in;
            de_d    <= de_in;
            hsync   <= hsync_d;
            vsync   <= vsync_d;
            de      <= de_d;
            rgb     <= de_d ? pick : '0;  // Black during blanking
        end
    end

endmodule

//--- vdp_pkg.sv
package vdp_pkg;

    // Raster geometry, kept small for short simulations
    localparam int vdp_x_width      = 7;
    localparam int vdp_y_width      = 6;
    localparam int vdp_h_active     = 64;
    localparam int vdp_h_total      = 80;
    localparam int vdp_v_active     = 48;
    localparam int vdp_v_total      = 56;
    localparam int vdp_h_sync_start = 68;  // Inside horizontal blanking
    localparam int vdp_h_sync_len   = 6;
    localparam int vdp_v_sync_start = 50;  // Inside vertical blanking
    localparam int vdp_v_sync_len   = 2;

    // Sprites
    localparam int vdp_sprite_count              = 4;
    localparam int vdp_sprite_index_width        = 2;
    localparam int vdp_sprite_width              = 8;
    localparam int vdp_sprite_height             = 8;
    localparam int vdp_sprite_row_index_width    = 3;
    localparam int vdp_sprite_column_index_width = 3;

    // Colour; the extra top bit of a stored pixel marks it opaque
    localparam int vdp_rgb_width  = 3;
    localparam int vdp_ergb_width = 4;

    // Host bus and register map, word addresses
    localparam int vdp_wb_data_width  = 32;
    localparam int vdp_wb_addr_width  = 8;
    localparam int vdp_wb_sel_width   = 4;
    localparam int vdp_adr_bg_bit     = 7;  // Set selects background
    localparam int vdp_adr_row_bit    = 4;  // Set selects a row word
    localparam int vdp_adr_sprite_lsb = 5;  // Sprite index in bits 6..5

    // Position word layout
    localparam int vdp_xy_enable_bit = 31;
    localparam int vdp_xy_x_lsb      = 0;
    localparam int vdp_xy_y_lsb      = 16;

    typedef enum logic [1:0] {reg_xy, reg_row, reg_bg, reg_none} vdp_reg_e;

    typedef enum logic {wb_idle, wb_ack} vdp_wb_state_e;

endpackage

//--- vdp_sprite.sv
`timescale 1ns/1ps

module vdp_sprite
(
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic [vdp_pkg::vdp_x_width - 1:0]                 pixel_x,
    input  logic [vdp_pkg::vdp_y_width - 1:0]                 pixel_y,
    input  logic [vdp_pkg::vdp_wb_data_width - 1:0]           wr_data,
    input  logic                                              xy_we,
    input  logic                                              row_we,
    input  logic [vdp_pkg::vdp_sprite_row_index_width - 1:0]  wr_row_index,
    output logic                                              rgb_en,
    output logic [vdp_pkg::vdp_rgb_width - 1:0]               rgb
);
    import vdp_pkg::*;

    logic                                             sprite_en;
    logic [vdp_x_width - 1:0]                         sprite_x;
    logic [vdp_y_width - 1:0]                         sprite_y;
    logic [vdp_sprite_width * vdp_ergb_width - 1:0]   rows [vdp_sprite_height];

    logic [vdp_x_width:0]                             x_off;
    logic [vdp_y_width:0]                             y_off;
    logic                                             x_hit;
    logic                                             y_hit;
    logic [vdp_sprite_column_index_width - 1:0]       column_index;
    logic [vdp_sprite_row_index_width - 1:0]          row_index;
    logic [vdp_sprite_width * vdp_ergb_width - 1:0]   row;
    logic [vdp_ergb_width - 1:0]                      ergb;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            sprite_en <= 1'b0;
        else if (xy_we)
            sprite_en <= wr_data[vdp_xy_enable_bit];
    end

    always_ff @(posedge clk)
    begin
        if (xy_we)
        begin
            sprite_x <= wr_data[vdp_xy_x_lsb +: vdp_x_width];
            sprite_y <= wr_data[vdp_xy_y_lsb +: vdp_y_width];
        end
        if (row_we)
            rows[wr_row_index] <= wr_data;
    end

    // One extra bit holds the borrow, so a pixel left of the sprite never wraps
    assign x_off = {1'b0, pixel_x} - {1'b0, sprite_x};
    assign y_off = {1'b0, pixel_y} - {1'b0, sprite_y};

    assign x_hit = !x_off[vdp_x_width]
                && (x_off[vdp_x_width - 1:0] < vdp_x_width'(vdp_sprite_width));
    assign y_hit = !y_off[vdp_y_width]
                && (y_off[vdp_y_width - 1:0] < vdp_y_width'(vdp_sprite_height));

    assign column_index = x_off[vdp_sprite_column_index_width - 1:0];
    assign row_index    = y_off[vdp_sprite_row_index_width - 1:0];
    assign row          = rows[row_index];
    assign ergb         = row[column_index * vdp_ergb_width +: vdp_ergb_width];  // Col 0 low

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rgb_en <= 1'b0;
        else
            rgb_en <= sprite_en && x_hit && y_hit && ergb[vdp_ergb_width - 1];
    end

    always_ff @(posedge clk)
        rgb <= ergb[vdp_rgb_width - 1:0];  // Only meaningful with rgb_en

    ap_en_needs_sprite: assert property (@(posedge clk) disable iff (reset)
        rgb_en |-> $past(sprite_en));

endmodule

//--- vdp_timing.sv
`timescale 1ns/1ps

module vdp_timing
(
    input  logic                                 clk,
    input  logic                                 reset,
    output logic [vdp_pkg::vdp_x_width - 1:0]    pixel_x,
    output logic [vdp_pkg::vdp_y_width - 1:0]    pixel_y,
    output logic                                 hsync,
    output logic                                 vsync,
    output logic                                 de
);
    import vdp_pkg::*;

    logic [vdp_x_width - 1:0] x_cnt;
    logic [vdp_y_width - 1:0] y_cnt;
    logic                     x_last;
    logic                     y_last;

    assign x_last = (x_cnt == vdp_x_width'(vdp_h_total - 1));
    assign y_last = (y_cnt == vdp_y_width'(vdp_v_total - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x_cnt <= '0;
            y_cnt <= '0;
        end
        else
        begin
            x_cnt <= x_last ? '0 : x_cnt + 1'b1;
            if (x_last)
                y_cnt <= y_last ? '0 : y_cnt + 1'b1;  // Next line at end of row
        end
    end

    // All outputs come from the same counter values, so they stay aligned
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pixel_x <= '0;
            pixel_y <= '0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            de      <= 1'b0;
        end
        else
        begin
            pixel_x <= x_cnt;
            pixel_y <= y_cnt;
            hsync   <= (x_cnt >= vdp_x_width'(vdp_h_sync_start))
                    && (x_cnt <  vdp_x_width'(vdp_h_sync_start + vdp_h_sync_len));
            vsync   <= (y_cnt >= vdp_y_width'(vdp_v_sync_start))
                    && (y_cnt <  vdp_y_width'(vdp_v_sync_start + vdp_v_sync_len));
            de      <= (x_cnt < vdp_x_width'(vdp_h_active))
                    && (y_cnt < vdp_y_width'(vdp_v_active));
        end
    end

    ap_x_in_frame: assert property (@(posedge clk) disable iff (reset)
        pixel_x < vdp_x_width'(vdp_h_total));

endmodule

//--- vdp_top.sv
`timescale 1ns/1ps

module vdp_top
(
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     cyc,
    input  logic                                     stb,
    input  logic                                     we,
    input  logic [vdp_pkg::vdp_wb_addr_width - 1:0]  adr,
    input  logic [vdp_pkg::vdp_wb_data_width - 1:0]  dat_w,
    input  logic [vdp_pkg::vdp_wb_sel_width - 1:0]   sel,
    output logic [vdp_pkg::vdp_wb_data_width - 1:0]  dat_r,
    output logic                                     ack,
    output logic                                     hsync,
    output logic                                     vsync,
    output logic                                     de,
    output logic [vdp_pkg::vdp_rgb_width - 1:0]      rgb
);
    import vdp_pkg::*;

    logic [vdp_wb_data_width - 1:0]               wr_data;
    logic [vdp_sprite_count - 1:0]                xy_we;
    logic [vdp_sprite_count - 1:0]                row_we;
    logic [vdp_sprite_row_index_width - 1:0]      wr_row_index;
    logic [vdp_rgb_width - 1:0]                   bg_rgb;

    logic [vdp_x_width - 1:0]                     pixel_x;
    logic [vdp_y_width - 1:0]                     pixel_y;
    logic                                         t_hsync;
    logic                                         t_vsync;
    logic                                         t_de;

    logic [vdp_sprite_count - 1:0]                sprite_en;
    logic [vdp_sprite_count * vdp_rgb_width - 1:0] sprite_rgb;

    vdp_wb_regs i_regs
    (
        .clk          (clk),
        .reset        (reset),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .sel          (sel),
        .dat_r        (dat_r),
        .ack          (ack),
        .wr_data      (wr_data),
        .xy_we        (xy_we),
        .row_we       (row_we),
        .wr_row_index (wr_row_index),
        .bg_rgb       (bg_rgb)
    );

    vdp_timing i_timing
    (
        .clk     (clk),
        .reset   (reset),
        .pixel_x (pixel_x),
        .pixel_y (pixel_y),
        .hsync   (t_hsync),
        .vsync   (t_vsync),
        .de      (t_de)
    );

    for (genvar i = 0; i < vdp_sprite_count; i++)
    begin : g_sprite
        vdp_sprite i_sprite
        (
            .clk          (clk),
            .reset        (reset),
            .pixel_x      (pixel_x),
            .pixel_y      (pixel_y),
            .wr_data      (wr_data),
            .xy_we        (xy_we[i]),
            .row_we       (row_we[i]),
            .wr_row_index (wr_row_index),
            .rgb_en       (sprite_en[i]),
            .rgb          (sprite_rgb[i * vdp_rgb_width +: vdp_rgb_width])
        );
    end

    vdp_mixer i_mixer
    (
        .clk        (clk),
        .reset      (reset),
        .sprite_en  (sprite_en),
        .sprite_rgb (sprite_rgb),
        .bg_rgb     (bg_rgb),
        .hsync_in   (t_hsync),
        .vsync_in   (t_vsync),
        .de_in      (t_de),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .rgb        (rgb)
    );

endmodule

//--- vdp_wb_regs.sv
`timescale 1ns/1ps

module vdp_wb_regs
(
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              cyc,
    input  logic                                              stb,
    input  logic                                              we,
    input  logic [vdp_pkg::vdp_wb_addr_width - 1:0]           adr,
    input  logic [vdp_pkg::vdp_wb_data_width - 1:0]           dat_w,
    input  logic [vdp_pkg::vdp_wb_sel_width - 1:0]            sel,
    output logic [vdp_pkg::vdp_wb_data_width - 1:0]           dat_r,
    output logic                                              ack,
    output logic [vdp_pkg::vdp_wb_data_width - 1:0]           wr_data,
    output logic [vdp_pkg::vdp_sprite_count - 1:0]            xy_we,
    output logic [vdp_pkg::vdp_sprite_count - 1:0]            row_we,
    output logic [vdp_pkg::vdp_sprite_row_index_width - 1:0]  wr_row_index,
    output logic [vdp_pkg::vdp_rgb_width - 1:0]               bg_rgb
);
    import vdp_pkg::*;

    vdp_wb_state_e                       state;
    vdp_reg_e                            reg_kind;
    logic [vdp_sprite_index_width - 1:0] sprite_index;
    logic                                access;
    logic                                write;

    assign access       = cyc && stb;
    assign write        = we && (sel != '0);  // Any byte lane writes the whole word
    assign sprite_index = adr[vdp_adr_sprite_lsb +: vdp_sprite_index_width];
    assign wr_row_index = adr[vdp_sprite_row_index_width - 1:0];
    assign wr_data      = dat_w;

    always_comb
    begin
        if (!access)
            reg_kind = reg_none;
        else if (adr[vdp_adr_bg_bit])
            reg_kind = reg_bg;
        else if (adr[vdp_adr_row_bit])
            reg_kind = reg_row;
        else
            reg_kind = reg_xy;
    end

    // wb_ack holds until stb drops, so one access gives one ack pulse
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= wb_idle;
            ack   <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            case (state)
                wb_idle:
                    if (access)
                    begin
                        state <= wb_ack;
                        ack   <= 1'b1;
                    end
                wb_ack:
                    if (!stb)
                        state <= wb_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            bg_rgb <= '0;
        else if (state == wb_idle && reg_kind == reg_bg && write)
            bg_rgb <= dat_w[vdp_rgb_width - 1:0];  // Same edge that raises ack
    end

    // Sprite strobes land on the edge that raises ack
    always_comb
    begin
        xy_we  = '0;
        row_we = '0;
        if (state == wb_idle && write)
        begin
            case (reg_kind)
                reg_xy:  xy_we[sprite_index]  = 1'b1;
                reg_row: row_we[sprite_index] = 1'b1;
                default: ;
            endcase
        end
    end

    assign dat_r = (reg_kind == reg_bg)
                 ? {{(vdp_wb_data_width - vdp_rgb_width){1'b0}}, bg_rgb}
                 : '0;

    ap_ack_needs_access: assert property (@(posedge clk) disable iff (reset)
        ack |-> cyc && stb);

    ap_strobe_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({xy_we, row_we}));

endmodule
